// ==== source/icache_pkg.sv ====
package icache_pkg;

  // address field widths
  localparam int ADDR_W      = 32;
  localparam int WORD_W      = 32;
  localparam int TAG_W       = 19;
  localparam int INDEX_W     = 7;
  localparam int WORD_SEL_W  = 4;
  localparam int OFFSET_W    = 2;
  localparam int BURST_LEN_W = 8;
  localparam int REGION_W    = 4;

  // bit positions of the fields inside a byte address
  localparam int WORD_LSB  = OFFSET_W;
  localparam int INDEX_LSB = WORD_LSB + WORD_SEL_W;
  localparam int TAG_LSB   = INDEX_LSB + INDEX_W;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [TAG_W-1:0]       tag_t;
  typedef logic [INDEX_W-1:0]     index_t;
  typedef logic [WORD_SEL_W-1:0]  word_sel_t;
  typedef logic [BURST_LEN_W-1:0] burst_len_t;

  // cache geometry, 8 KB direct mapped
  localparam int NUM_LINES      = 128;
  localparam int WORDS_PER_LINE = 16;

  // burst length field holds beats minus one
  localparam burst_len_t LINE_BURST_LEN   = 8'd15;
  localparam burst_len_t SINGLE_BURST_LEN = 8'd0;

  // top nibble of the uncached address region
  localparam logic [REGION_W-1:0] UNCACHED_REGION = 4'hA;

  typedef enum logic [2:0] {
    ST_RESET,
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_UNCACHED
  } fetch_state_t;

endpackage

// ==== source/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl import icache_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  addr_t      fetch_addr_i,
  input  logic       fetch_valid_i,
  input  logic       hit_i,
  input  logic       mem_rdata_ready_i,
  output addr_t      mem_raddr_o,
  output logic       mem_raddr_valid_o,
  output burst_len_t mem_rlen_o,
  output tag_t       lookup_tag_o,
  output index_t     lookup_index_o,
  output word_sel_t  lookup_word_o,
  output logic       tag_wen_o,
  output logic       line_wen_o,
  output word_sel_t  beat_o,
  output logic       lookup_hit_o,
  output logic       uncached_done_o
);

  fetch_state_t state_q;
  // captured fetch address
  addr_t        addr_q;
  // memory request, held until the last beat
  addr_t        raddr_q;
  logic         raddr_valid_q;
  burst_len_t   rlen_q;
  word_sel_t    beat_q;
  logic         tag_wen_q;

  logic uncached;
  logic mem_beat;
  logic last_beat;
  logic lookup_miss;
  logic lookup_uncached;
  logic capture;

  // split the captured address
  assign lookup_tag_o   = addr_q[ADDR_W-1:TAG_LSB];
  assign lookup_index_o = addr_q[TAG_LSB-1:INDEX_LSB];
  assign lookup_word_o  = addr_q[INDEX_LSB-1:WORD_LSB];

  // region decode on the top nibble
  assign uncached = (addr_q[ADDR_W-1 -: REGION_W] == UNCACHED_REGION);

  // one beat per cycle with valid and ready both high
  assign mem_beat  = raddr_valid_q & mem_rdata_ready_i;
  assign last_beat = (beat_q == rlen_q[WORD_SEL_W-1:0]);

  // lookup outcome, only meaningful in ST_LOOKUP
  assign lookup_hit_o    = (state_q == ST_LOOKUP) & ~uncached & hit_i;
  assign lookup_miss     = (state_q == ST_LOOKUP) & ~uncached & ~hit_i;
  assign lookup_uncached = (state_q == ST_LOOKUP) & uncached;

  // new address taken from idle, or right behind a hit
  assign capture = fetch_valid_i & ((state_q == ST_IDLE) | lookup_hit_o);

  // refill beats go into the line store
  assign line_wen_o      = (state_q == ST_REFILL) & mem_beat;
  assign uncached_done_o = (state_q == ST_UNCACHED) & mem_beat;
  assign beat_o          = beat_q;
  assign tag_wen_o       = tag_wen_q;

  assign mem_raddr_o       = raddr_q;
  assign mem_raddr_valid_o = raddr_valid_q;
  assign mem_rlen_o        = rlen_q;

  // address and request payload
  always_ff @(posedge clk) begin
    if (capture) begin
      addr_q <= fetch_addr_i;
    end
    if (lookup_miss) begin
      // line base, word and byte bits cleared
      raddr_q <= {addr_q[ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
      rlen_q  <= LINE_BURST_LEN;
    end else if (lookup_uncached) begin
      // exact word, single beat
      raddr_q <= addr_q;
      rlen_q  <= SINGLE_BURST_LEN;
    end
  end

  // fetch state machine
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= ST_RESET;
      raddr_valid_q <= 1'b0;
      beat_q        <= '0;
      tag_wen_q     <= 1'b0;
    end else begin
      tag_wen_q <= 1'b0;
      case (state_q)
        ST_RESET: begin
          state_q <= ST_IDLE;
        end
        ST_IDLE: begin
          if (fetch_valid_i) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (uncached) begin
            raddr_valid_q <= 1'b1;
            state_q       <= ST_UNCACHED;
          end else if (hit_i) begin
            // stay here while hits keep coming
            if (!fetch_valid_i) begin
              state_q <= ST_IDLE;
            end
          end else begin
            raddr_valid_q <= 1'b1;
            beat_q        <= '0;
            state_q       <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          if (mem_beat) begin
            if (last_beat) begin
              // burst done, tag goes in next cycle
              raddr_valid_q <= 1'b0;
              tag_wen_q     <= 1'b1;
              state_q       <= ST_IDLE;
            end else begin
              beat_q <= beat_q + word_sel_t'(1);
            end
          end
        end
        ST_UNCACHED: begin
          if (mem_beat) begin
            raddr_valid_q <= 1'b0;
            state_q       <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== source/tag_store.sv ====
`timescale 1ns/1ps

module tag_store import icache_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  tag_t   lookup_tag_i,
  input  index_t lookup_index_i,
  input  logic   tag_wen_i,
  output logic   hit_o
);

  // one valid bit per line
  logic [NUM_LINES-1:0] valid_q;
  // one tag per line
  tag_t                 tags_q [NUM_LINES];

  // combinational compare for the current index
  assign hit_o = valid_q[lookup_index_i] & (tags_q[lookup_index_i] == lookup_tag_i);

  // valid bits, cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_wen_i) begin
      valid_q[lookup_index_i] <= 1'b1;
    end
  end

  // tag array
  always_ff @(posedge clk) begin
    if (tag_wen_i) begin
      tags_q[lookup_index_i] <= lookup_tag_i;
    end
  end

endmodule

// ==== source/line_store.sv ====
`timescale 1ns/1ps

module line_store import icache_pkg::*; (
  input  logic      clk,
  input  index_t    index_i,
  input  word_sel_t word_i,
  input  word_sel_t beat_i,
  input  logic      wen_i,
  input  word_t     wdata_i,
  output word_t     rdata_o
);

  // 128 lines of 16 words, addressed by {index, word}
  word_t mem_q [NUM_LINES*WORDS_PER_LINE];

  // refill writes at the beat position of the line
  always_ff @(posedge clk) begin
    if (wen_i) begin
      mem_q[{index_i, beat_i}] <= wdata_i;
    end
  end

  // asynchronous read of the fetched word
  assign rdata_o = mem_q[{index_i, word_i}];

endmodule

// ==== source/fetch_resp.sv ====
`timescale 1ns/1ps

module fetch_resp import icache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  lookup_hit_i,
  input  logic  uncached_done_i,
  input  word_t cache_word_i,
  input  word_t mem_rdata_i,
  output word_t fetch_rdata_o,
  output logic  fetch_rdata_valid_o
);

  // uncached word kept for the return cycle
  word_t uncached_word_q;
  logic  uncached_valid_q;

  always_ff @(posedge clk) begin
    if (uncached_done_i) begin
      uncached_word_q <= mem_rdata_i;
    end
  end

  // strobe one cycle after the single beat
  always_ff @(posedge clk) begin
    if (rst) begin
      uncached_valid_q <= 1'b0;
    end else begin
      uncached_valid_q <= uncached_done_i;
    end
  end

  // hit word has priority, else the latched uncached word
  assign fetch_rdata_valid_o = lookup_hit_i | uncached_valid_q;
  assign fetch_rdata_o       = lookup_hit_i ? cache_word_i : uncached_word_q;

endmodule

// ==== source/icache_top.sv ====
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // cpu fetch side
  input  addr_t      fetch_addr_i,
  input  logic       fetch_valid_i,
  output word_t      fetch_rdata_o,
  output logic       fetch_rdata_valid_o,
  // memory read side
  output addr_t      mem_raddr_o,
  output logic       mem_raddr_valid_o,
  output burst_len_t mem_rlen_o,
  input  logic       mem_rdata_ready_i,
  input  word_t      mem_rdata_i
);

  // lookup address fields of the captured fetch
  tag_t      lookup_tag;
  index_t    lookup_index;
  word_sel_t lookup_word;
  logic      hit;
  logic      tag_wen;
  // refill write path
  logic      line_wen;
  word_sel_t beat;
  // response control
  logic      lookup_hit;
  logic      uncached_done;
  word_t     cache_word;

  fetch_ctrl fetch_ctrl_inst (
    .clk               (clk),
    .rst               (rst),
    .fetch_addr_i      (fetch_addr_i),
    .fetch_valid_i     (fetch_valid_i),
    .hit_i             (hit),
    .mem_rdata_ready_i (mem_rdata_ready_i),
    .mem_raddr_o       (mem_raddr_o),
    .mem_raddr_valid_o (mem_raddr_valid_o),
    .mem_rlen_o        (mem_rlen_o),
    .lookup_tag_o      (lookup_tag),
    .lookup_index_o    (lookup_index),
    .lookup_word_o     (lookup_word),
    .tag_wen_o         (tag_wen),
    .line_wen_o        (line_wen),
    .beat_o            (beat),
    .lookup_hit_o      (lookup_hit),
    .uncached_done_o   (uncached_done)
  );

  tag_store tag_store_inst (
    .clk            (clk),
    .rst            (rst),
    .lookup_tag_i   (lookup_tag),
    .lookup_index_i (lookup_index),
    .tag_wen_i      (tag_wen),
    .hit_o          (hit)
  );

  // write data comes straight from the memory bus
  line_store line_store_inst (
    .clk     (clk),
    .index_i (lookup_index),
    .word_i  (lookup_word),
    .beat_i  (beat),
    .wen_i   (line_wen),
    .wdata_i (mem_rdata_i),
    .rdata_o (cache_word)
  );

  fetch_resp fetch_resp_inst (
    .clk                 (clk),
    .rst                 (rst),
    .lookup_hit_i        (lookup_hit),
    .uncached_done_i     (uncached_done),
    .cache_word_i        (cache_word),
    .mem_rdata_i         (mem_rdata_i),
    .fetch_rdata_o       (fetch_rdata_o),
    .fetch_rdata_valid_o (fetch_rdata_valid_o)
  );

endmodule

// ==== verification/icache_assertions.sv ====
`timescale 1ns/1ps

module icache_assertions import icache_pkg::*; (
  input logic       clk,
  input logic       rst,
  input addr_t      mem_raddr_o,
  input logic       mem_raddr_valid_o,
  input burst_len_t mem_rlen_o,
  input logic       mem_rdata_ready_i,
  input logic       fetch_rdata_valid_o
);

  // failed assertions so far
  int fail_count = 0;

  // a waiting request keeps valid, address and length
  request_held: assert property (@(posedge clk) disable iff (rst)
    mem_raddr_valid_o && !mem_rdata_ready_i
      |=> mem_raddr_valid_o && $stable(mem_raddr_o) && $stable(mem_rlen_o))
    else begin
      $error("memory request changed while waiting for ready");
      fail_count++;
    end

  // single words inside the uncached region and line bursts outside it
  burst_len_legal: assert property (@(posedge clk) disable iff (rst)
    mem_raddr_valid_o |-> (mem_rlen_o ==
      ((mem_raddr_o[ADDR_W-1 -: REGION_W] == UNCACHED_REGION) ?
        SINGLE_BURST_LEN : LINE_BURST_LEN)))
    else begin
      $error("burst length %0d does not match region of %h", mem_rlen_o, mem_raddr_o);
      fail_count++;
    end

  // no fetch response while memory is still busy
  no_resp_during_req: assert property (@(posedge clk) disable iff (rst)
    !(fetch_rdata_valid_o && mem_raddr_valid_o))
    else begin
      $error("fetch response strobed during an open memory request");
      fail_count++;
    end

endmodule

// ==== verification/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

  // tests take about 600 cycles with random ready
  localparam int    MAX_CYCLES = 2000;
  localparam addr_t ADDR_A     = 32'h0000_1234;
  // same index as ADDR_A, tag one higher
  localparam addr_t ADDR_B     = 32'h0000_3234;
  localparam addr_t ADDR_U     = 32'hA000_0100;

  logic       clk = 1'b0;
  logic       rst;
  addr_t      fetch_addr_i;
  logic       fetch_valid_i;
  word_t      fetch_rdata_o;
  logic       fetch_rdata_valid_o;
  addr_t      mem_raddr_o;
  logic       mem_raddr_valid_o;
  burst_len_t mem_rlen_o;
  logic       mem_rdata_ready_i;
  word_t      mem_rdata_i;

  int          error_count  = 0;
  int          check_count  = 0;
  int          failed_tests = 0;
  int          cycle_count  = 0;
  // memory model state sampled on the falling edge
  logic        req_seen     = 1'b0;
  addr_t       req_addr;
  burst_len_t  req_len;
  int          beat_idx     = 0;
  int          req_count    = 0;
  int          req_beats    = 0;
  logic        random_ready = 1'b0;
  logic [31:0] rng_state    = 32'h091e_fabc;
  // result of the last fetch
  word_t       got_word;
  int          got_reqs;

  icache_top icache_top_inst (.*);

  bind icache_top icache_assertions icache_assertions_inst (
    .clk(clk), .rst(rst), .mem_raddr_o(mem_raddr_o), .mem_raddr_valid_o(mem_raddr_valid_o),
    .mem_rlen_o(mem_rlen_o), .mem_rdata_ready_i(mem_rdata_ready_i),
    .fetch_rdata_valid_o(fetch_rdata_valid_o)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) begin
      $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // memory word is its own address xor a fixed pattern
  function automatic word_t mem_word(input addr_t a);
    return a ^ 32'h5a5a_5a5a;
  endfunction

  // track requests and count the beats taken at the next rising edge
  always @(negedge clk) begin
    if (mem_raddr_valid_o && !req_seen) begin
      req_count = req_count + 1;
      req_addr  = mem_raddr_o;
      req_len   = mem_rlen_o;
      beat_idx  = 0;
    end
    if (!mem_raddr_valid_o && req_seen) begin
      req_beats = beat_idx;
    end
    if (mem_raddr_valid_o && mem_rdata_ready_i) begin
      beat_idx = beat_idx + 1;
    end
    req_seen = mem_raddr_valid_o;
  end

  // data for the pending beat starts one cycle after the request
  always @(posedge clk) begin
    rng_state = next_random(rng_state);
    if (req_seen) begin
      mem_rdata_i       <= mem_word(req_addr + addr_t'(beat_idx * 4));
      mem_rdata_ready_i <= random_ready ? rng_state[7] : 1'b1;
    end else begin
      mem_rdata_ready_i <= 1'b0;
    end
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (error_count != errs_before) begin
      failed_tests++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // wait until no strobe and no request for a few cycles
  // repeated strobes for the held address must carry the same word
  task automatic drain(input addr_t addr);
    int quiet;
    quiet = 0;
    while (quiet < 3) begin
      @(negedge clk);
      if (fetch_rdata_valid_o) begin
        compare("fetch_rdata_o", fetch_rdata_o, mem_word(addr));
      end
      quiet = (fetch_rdata_valid_o || mem_raddr_valid_o) ? 0 : quiet + 1;
    end
    @(posedge clk);
  endtask

  // hold address and valid until the response strobe
  task automatic fetch(input addr_t addr);
    int reqs_before;
    @(posedge clk);
    reqs_before = req_count;
    fetch_addr_i  <= addr;
    fetch_valid_i <= 1'b1;
    do begin
      @(negedge clk);
    end while (fetch_rdata_valid_o !== 1'b1);
    got_word = fetch_rdata_o;
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    got_reqs = req_count - reqs_before;
    compare("fetch_rdata_o", got_word, mem_word(addr));
    drain(addr);
  endtask

  task automatic reset_values();
    int errs;
    errs = error_count;
    @(negedge clk);
    compare("mem_raddr_valid_o", mem_raddr_valid_o, 1'b0);
    compare("fetch_rdata_valid_o", fetch_rdata_valid_o, 1'b0);
    finish_test("reset", errs);
  endtask

  task automatic cold_miss();
    int errs;
    errs = error_count;
    fetch(ADDR_A);
    compare("request count", got_reqs, 1);
    compare("mem_raddr_o", req_addr, ADDR_A & ~32'h3f);
    compare("mem_rlen_o", req_len, 15);
    compare("burst beats", req_beats, 16);
    finish_test("cold_miss", errs);
  endtask

  // next address goes out on each capture edge for one word per cycle
  task automatic hit_stream();
    int    errs;
    int    reqs_before;
    int    i;
    addr_t base;
    errs = error_count;
    base = ADDR_A & ~32'h3f;
    @(posedge clk);
    reqs_before = req_count;
    fetch_addr_i  <= base;
    fetch_valid_i <= 1'b1;
    for (i = 0; i < 16; i++) begin
      @(posedge clk);
      if (i < 15) begin
        fetch_addr_i <= base + addr_t'((i + 1) * 4);
      end else begin
        fetch_valid_i <= 1'b0;
      end
      @(negedge clk);
      compare("fetch_rdata_valid_o", fetch_rdata_valid_o, 1'b1);
      compare("fetch_rdata_o", fetch_rdata_o, mem_word(base + addr_t'(i * 4)));
    end
    @(posedge clk);
    compare("request count", req_count - reqs_before, 0);
    finish_test("hit_stream", errs);
  endtask

  task automatic uncached_fetch();
    int errs;
    errs = error_count;
    fetch(ADDR_U);
    compare("request count", got_reqs, 1);
    compare("mem_raddr_o", req_addr, ADDR_U);
    compare("mem_rlen_o", req_len, 0);
    compare("burst beats", req_beats, 1);
    // never cached, so memory is asked again
    fetch(ADDR_U);
    compare("request count", got_reqs, 1);
    finish_test("uncached", errs);
  endtask

  task automatic conflict_eviction();
    int errs;
    errs = error_count;
    fetch(ADDR_B);
    compare("request count", got_reqs, 1);
    compare("mem_raddr_o", req_addr, ADDR_B & ~32'h3f);
    // B evicted A from the shared line
    fetch(ADDR_A);
    compare("request count", got_reqs, 1);
    compare("mem_raddr_o", req_addr, ADDR_A & ~32'h3f);
    finish_test("conflict", errs);
  endtask

  task automatic backpressure_mix();
    int    errs;
    int    i;
    addr_t seq [8];
    errs = error_count;
    seq = '{32'h0000_1238, 32'hA000_0204, 32'h0000_0440, 32'h0000_0444,
            32'hA004_0008, 32'h0000_3230, 32'h0000_1238, 32'h0000_047c};
    random_ready = 1'b1;
    for (i = 0; i < 8; i++) begin
      fetch(seq[i]);
    end
    random_ready = 1'b0;
    finish_test("backpressure", errs);
  endtask

  initial begin
    rst               = 1'b1;
    fetch_addr_i      = '0;
    fetch_valid_i     = 1'b0;
    mem_rdata_ready_i = 1'b0;
    mem_rdata_i       = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    reset_values();
    cold_miss();
    hit_stream();
    uncached_fetch();
    conflict_eviction();
    backpressure_mix();
    $display("tests: 6, failed tests: %0d, checks: %0d, failed checks: %0d, assertion fails: %0d",
             failed_tests, check_count, error_count,
             icache_top_inst.icache_assertions_inst.fail_count);
    if (error_count == 0 && icache_top_inst.icache_assertions_inst.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== icache.f ====
source/icache_pkg.sv
source/fetch_ctrl.sv
source/tag_store.sv
source/line_store.sv
source/fetch_resp.sv
source/icache_top.sv
verification/icache_assertions.sv
verification/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - source/icache_pkg.sv
  - source/fetch_ctrl.sv
  - source/tag_store.sv
  - source/line_store.sv
  - source/fetch_resp.sv
  - source/icache_top.sv
  - target: test
    files:
      - verification/icache_assertions.sv
      - verification/icache_tb.sv
